// ==== hdl/j4_io_pkg.sv ====
package j4_io_pkg;

  typedef logic [15:0] io_word_t;  // one data word on the io bus
  typedef logic [1:0]  slot_t;     // barrel slot number, 0 to 3
  typedef logic [15:0] io_addr_t;  // one-hot io address, bits may combine

  // io address bit positions
  localparam int IO_GPIO       = 0;   // gpio pins, masked write
  localparam int IO_GPIO_DIR   = 1;   // gpio direction, 1 = output
  localparam int IO_LEDS       = 2;
  localparam int IO_TASK1      = 8;   // task word of slot 1
  localparam int IO_TASK2      = 9;
  localparam int IO_TASK3      = 10;
  localparam int IO_SAMPLE     = 11;  // sample store data port
  localparam int IO_MISC       = 13;  // misc out on write, status on read
  localparam int IO_TASK_FETCH = 14;  // task fetch on read, kill word on write
  localparam int IO_TICKS_MASK = 15;  // tick counter on read, mask preset on write

  // layout of the misc word when written
  typedef struct packed {
    logic       rsvd_top;       // was warm boot on the board
    logic       flash_sck;
    logic       flash_mosi;
    logic       flash_cs;
    logic       set_write_ptr;  // preset sample write pointer
    logic       set_read_ptr;   // preset sample read pointer
    logic [1:0] rsvd_mid;
    logic [7:0] sample_addr;    // value loaded into the pointers
  } misc_flags_t;

  // write word seen either as plain data or as misc flags
  typedef union packed {
    io_word_t    raw;
    misc_flags_t misc;
  } io_wdata_u;

  // what the host presents with req
  typedef struct packed {
    logic     wr;
    slot_t    slot;
    io_addr_t addr;
    io_word_t wdata;
  } io_req_t;

  // single-cycle access strobe seen by every io block
  typedef struct packed {
    logic      valid;  // high for exactly one cycle per request
    logic      wr;     // 0 means read
    slot_t     slot;
    io_addr_t  addr;   // all zero when not valid
    io_wdata_u wdata;
  } io_access_t;

endpackage

// ==== hdl/io_bus_port.sv ====
`timescale 1ns/1ps

module io_bus_port (
  input  logic                  clk,
  input  logic                  resetq,
  input  logic                  req,
  input  j4_io_pkg::io_req_t    request,
  output logic                  ack,
  output j4_io_pkg::io_word_t   rdata,
  output j4_io_pkg::io_access_t access,
  input  j4_io_pkg::io_word_t   read_word
);
  import j4_io_pkg::*;

  // handshake states
  localparam logic [1:0] ST_IDLE   = 2'd0;  // waiting for req
  localparam logic [1:0] ST_STROBE = 2'd1;  // access on the bus this cycle
  localparam logic [1:0] ST_ACKED  = 2'd2;  // ack high until req drops

  logic [1:0] state;
  logic       req_q;    // req as sampled at the last edge
  logic       strobe;
  io_req_t    req_lat;  // request held through the strobe cycle

  assign strobe = (state == ST_STROBE);

  always_ff @(posedge clk) begin
    if (!resetq) begin
      state <= ST_IDLE;
      req_q <= 1'b0;
      ack   <= 1'b0;
    end else begin
      req_q <= req;
      case (state)
        ST_IDLE:
          if (req_q) state <= ST_STROBE;  // one access per req
        ST_STROBE: begin
          state <= ST_ACKED;
          ack   <= 1'b1;                  // rdata lands at this same edge
        end
        ST_ACKED:
          if (!req_q) begin               // host let go, finish the cycle
            state <= ST_IDLE;
            ack   <= 1'b0;
          end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // payload, only meaningful alongside the state above
  always_ff @(posedge clk) begin
    if (state == ST_IDLE) req_lat <= request;  // host keeps it stable under req
    if (strobe) rdata <= read_word;            // held while ack is up
  end

  always_comb begin
    access.valid     = strobe;
    access.wr        = req_lat.wr;
    access.slot      = req_lat.slot;
    access.addr      = strobe ? req_lat.addr : '0;  // nothing actuates between strobes
    access.wdata.raw = req_lat.wdata;
  end

endmodule

// ==== hdl/io_mask_bank.sv ====
`timescale 1ns/1ps

module io_mask_bank (
  input  logic                  clk,
  input  logic                  resetq,
  input  j4_io_pkg::io_access_t access,
  output j4_io_pkg::io_word_t   mask
);
  import j4_io_pkg::*;

  // one mask per slot, so threads sharing a port do not disturb each other
  io_word_t masks [4];
  logic     set_mask;

  // a write at bit 15 presets the mask for the slot's next access
  assign set_mask = access.wr && access.addr[IO_TICKS_MASK];

  always_ff @(posedge clk) begin
    if (!resetq) begin
      for (int s = 0; s < 4; s++) begin
        masks[s] <= '1;  // all bits pass
      end
    end else if (access.valid) begin
      if (set_mask)
        masks[access.slot] <= access.wdata.raw;
      else
        masks[access.slot] <= '1;  // used once, then back to all ones
    end
  end

  // mask in force for the slot on the bus right now
  assign mask = masks[access.slot];

endmodule

// ==== hdl/task_slot.sv ====
`timescale 1ns/1ps

module task_slot #(
  parameter int SLOT_ID = 1  // 1 to 3, slot 0 never gets a task
) (
  input  logic                  clk,
  input  logic                  resetq,
  input  j4_io_pkg::io_access_t access,
  output j4_io_pkg::io_word_t   task_word
);
  import j4_io_pkg::*;

  localparam int TASK_BIT = IO_TASK1 - 1 + SLOT_ID;  // address bit of this slot

  logic load;
  logic fetch;

  // any slot may assign work to this one
  assign load = access.valid && access.wr && access.addr[TASK_BIT];

  // only the owning slot fetches its own task
  assign fetch = access.valid && !access.wr && access.addr[IO_TASK_FETCH] &&
                 (access.slot == slot_t'(SLOT_ID));

  always_ff @(posedge clk) begin
    if (!resetq) begin
      task_word <= '0;  // zero task keeps the slot spinning idle
    end else if (load) begin
      task_word <= access.wdata.raw;
    end else if (fetch && task_word[0]) begin
      task_word <= '0;  // odd xt means run once
    end
  end

endmodule

// ==== hdl/sample_store.sv ====
`timescale 1ns/1ps

module sample_store (
  input  logic                  clk,
  input  logic                  resetq,
  input  j4_io_pkg::io_access_t access,
  output j4_io_pkg::io_word_t   sample
);
  import j4_io_pkg::*;

  io_word_t   mem [256];  // 256 x 16 sample words
  logic [7:0] rd_ptr;
  logic [7:0] wr_ptr;
  logic       have_read;
  logic       have_write;
  logic       misc_write;
  logic       set_rd;
  logic       set_wr;

  assign have_read  = access.valid && !access.wr && access.addr[IO_SAMPLE];
  assign have_write = access.valid && access.wr && access.addr[IO_SAMPLE];
  assign misc_write = access.valid && access.wr && access.addr[IO_MISC];

  // both flags together rewind the whole store
  assign set_rd = misc_write && access.wdata.misc.set_read_ptr;
  assign set_wr = misc_write && access.wdata.misc.set_write_ptr;

  always_ff @(posedge clk) begin
    if (!resetq) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
    end else begin
      if (set_rd)
        rd_ptr <= access.wdata.misc.sample_addr;
      else if (have_read)
        rd_ptr <= rd_ptr + 8'd1;   // step after the word is taken
      if (set_wr)
        wr_ptr <= access.wdata.misc.sample_addr;
      else if (have_write)
        wr_ptr <= wr_ptr + 8'd1;   // wraps at 256
    end
  end

  // storage array
  always_ff @(posedge clk) begin
    if (have_write) mem[wr_ptr] <= access.wdata.raw;
  end

  assign sample = mem[rd_ptr];  // word under the read pointer, no latency

endmodule

// ==== hdl/io_control_regs.sv ====
`timescale 1ns/1ps

module io_control_regs #(
  parameter int GPIO_BITS = 16,  // 1 to 16
  parameter int LED_BITS  = 8
) (
  input  logic                  clk,
  input  logic                  resetq,
  input  j4_io_pkg::io_access_t access,
  input  j4_io_pkg::io_word_t   mask,
  output logic [GPIO_BITS-1:0]  gpio_out,
  output logic [GPIO_BITS-1:0]  gpio_oe,
  output logic [LED_BITS-1:0]   leds,
  output logic                  flash_sck,
  output logic                  flash_mosi,
  output logic                  flash_cs,
  output logic [3:0]            kill_slots,
  output j4_io_pkg::io_word_t   ticks
);
  import j4_io_pkg::*;

  logic                 wr_any;
  logic [GPIO_BITS-1:0] gpio_mask;
  logic [GPIO_BITS-1:0] gpio_wd;
  logic [LED_BITS-1:0]  led_mask;
  logic [LED_BITS-1:0]  led_wd;

  assign wr_any = access.valid && access.wr;

  // low bits of mask and data line up with the pins
  assign gpio_mask = mask[GPIO_BITS-1:0];
  assign gpio_wd   = access.wdata.raw[GPIO_BITS-1:0];
  assign led_mask  = mask[LED_BITS-1:0];
  assign led_wd    = access.wdata.raw[LED_BITS-1:0];

  always_ff @(posedge clk) begin
    if (!resetq) begin
      gpio_out   <= '0;
      gpio_oe    <= '0;     // every pin starts as input
      leds       <= '0;
      flash_sck  <= 1'b0;
      flash_mosi <= 1'b0;
      flash_cs   <= 1'b1;   // flash deselected
      kill_slots <= 4'd0;
    end else if (wr_any) begin
      // masked writes, cleared mask bits keep their old value
      if (access.addr[IO_GPIO])
        gpio_out <= (gpio_out & ~gpio_mask) | (gpio_wd & gpio_mask);
      if (access.addr[IO_GPIO_DIR])
        gpio_oe <= (gpio_oe & ~gpio_mask) | (gpio_wd & gpio_mask);
      if (access.addr[IO_LEDS])
        leds <= (leds & ~led_mask) | (led_wd & led_mask);

      // flash pins are bit-banged through the misc word
      if (access.addr[IO_MISC]) begin
        flash_sck  <= access.wdata.misc.flash_sck;
        flash_mosi <= access.wdata.misc.flash_mosi;
        flash_cs   <= access.wdata.misc.flash_cs;
      end

      // kill request lasts until the next write of any kind
      kill_slots <= access.addr[IO_TASK_FETCH] ? access.wdata.raw[3:0] : 4'd0;
    end
  end

  // free-running wall clock, wraps
  always_ff @(posedge clk) begin
    if (!resetq)
      ticks <= '0;
    else
      ticks <= ticks + 16'd1;
  end

endmodule

// ==== hdl/io_read_mux.sv ====
`timescale 1ns/1ps

module io_read_mux #(
  parameter int GPIO_BITS = 16,
  parameter int LED_BITS  = 8
) (
  input  j4_io_pkg::io_access_t access,
  input  j4_io_pkg::io_word_t   mask,
  input  j4_io_pkg::io_word_t   task_words [1:3],
  input  j4_io_pkg::io_word_t   sample,
  input  j4_io_pkg::io_word_t   ticks,
  input  logic [GPIO_BITS-1:0]  gpio_in,
  input  logic [GPIO_BITS-1:0]  gpio_oe,
  input  logic [LED_BITS-1:0]   leds,
  input  logic                  flash_sck,
  input  logic                  flash_mosi,
  input  logic                  flash_cs,
  input  logic                  flash_miso,
  output j4_io_pkg::io_word_t   read_word
);
  import j4_io_pkg::*;

  io_word_t gpio_in_w;  // sources widened to a full word
  io_word_t gpio_oe_w;
  io_word_t leds_w;
  io_word_t status;
  io_word_t fetched;
  io_word_t merged;     // OR of every selected source

  always_comb begin
    gpio_in_w = '0;
    gpio_oe_w = '0;
    leds_w    = '0;
    gpio_in_w[GPIO_BITS-1:0] = gpio_in;
    gpio_oe_w[GPIO_BITS-1:0] = gpio_oe;
    leds_w[LED_BITS-1:0]     = leds;
  end

  // msb tells a thread it is not running on slot 0
  assign status = {(|access.slot), 11'd0, flash_sck, flash_mosi, flash_cs, flash_miso};

  // task handed to the fetching slot, run-once flag stripped
  always_comb begin
    case (access.slot)
      2'd1:    fetched = {task_words[1][15:1], 1'b0};
      2'd2:    fetched = {task_words[2][15:1], 1'b0};
      2'd3:    fetched = {task_words[3][15:1], 1'b0};
      default: fetched = '0;  // slot 0 gets nothing to run
    endcase
  end

  always_comb begin
    merged = '0;
    if (access.addr[IO_GPIO])       merged |= gpio_in_w;
    if (access.addr[IO_GPIO_DIR])   merged |= gpio_oe_w;
    if (access.addr[IO_LEDS])       merged |= leds_w;
    if (access.addr[IO_TASK1])      merged |= task_words[1];
    if (access.addr[IO_TASK2])      merged |= task_words[2];
    if (access.addr[IO_TASK3])      merged |= task_words[3];
    if (access.addr[IO_SAMPLE])     merged |= sample;
    if (access.addr[IO_MISC])       merged |= status;
    if (access.addr[IO_TASK_FETCH]) merged |= fetched;
    if (access.addr[IO_TICKS_MASK]) merged |= ticks;
    // bits 3 to 7 and 12 have no source
  end

  // cleared mask bits read back as zero
  assign read_word = merged & mask;

endmodule

// ==== hdl/j4_io_top.sv ====
`timescale 1ns/1ps

module j4_io_top #(
  parameter int GPIO_BITS = 16,
  parameter int LED_BITS  = 8
) (
  input  logic                 clk,
  input  logic                 resetq,
  input  logic                 req,
  input  j4_io_pkg::io_req_t   request,
  output logic                 ack,
  output j4_io_pkg::io_word_t  rdata,
  input  logic [GPIO_BITS-1:0] gpio_in,
  output logic [GPIO_BITS-1:0] gpio_out,
  output logic [GPIO_BITS-1:0] gpio_oe,
  output logic [LED_BITS-1:0]  leds,
  output logic                 flash_sck,
  output logic                 flash_mosi,
  output logic                 flash_cs,
  input  logic                 flash_miso,
  output logic [3:0]           kill_slots
);
  import j4_io_pkg::*;

  io_access_t access;      // one-cycle strobe to all io blocks
  io_word_t   mask;        // mask of the slot on the bus
  io_word_t   read_word;   // masked read data back to the port
  io_word_t   task_words [1:3];
  io_word_t   sample;
  io_word_t   ticks;

  io_bus_port u_io_bus_port (
    .clk       (clk),
    .resetq    (resetq),
    .req       (req),
    .request   (request),
    .ack       (ack),
    .rdata     (rdata),
    .access    (access),
    .read_word (read_word)
  );

  io_mask_bank u_io_mask_bank (
    .clk    (clk),
    .resetq (resetq),
    .access (access),
    .mask   (mask)
  );

  // slots 1 to 3 each own a task word
  for (genvar s = 1; s <= 3; s++) begin : g_task
    task_slot #(.SLOT_ID(s)) u_task_slot (
      .clk       (clk),
      .resetq    (resetq),
      .access    (access),
      .task_word (task_words[s])
    );
  end

  sample_store u_sample_store (
    .clk    (clk),
    .resetq (resetq),
    .access (access),
    .sample (sample)
  );

  io_control_regs #(.GPIO_BITS(GPIO_BITS), .LED_BITS(LED_BITS)) u_io_control_regs (
    .clk        (clk),
    .resetq     (resetq),
    .access     (access),
    .mask       (mask),
    .gpio_out   (gpio_out),
    .gpio_oe    (gpio_oe),
    .leds       (leds),
    .flash_sck  (flash_sck),
    .flash_mosi (flash_mosi),
    .flash_cs   (flash_cs),
    .kill_slots (kill_slots),
    .ticks      (ticks)
  );

  io_read_mux #(.GPIO_BITS(GPIO_BITS), .LED_BITS(LED_BITS)) u_io_read_mux (
    .access     (access),
    .mask       (mask),
    .task_words (task_words),
    .sample     (sample),
    .ticks      (ticks),
    .gpio_in    (gpio_in),
    .gpio_oe    (gpio_oe),
    .leds       (leds),
    .flash_sck  (flash_sck),
    .flash_mosi (flash_mosi),
    .flash_cs   (flash_cs),
    .flash_miso (flash_miso),
    .read_word  (read_word)
  );

endmodule

// ==== testbench/tb_j4_io_table.svh ====
`ifndef TB_J4_IO_TABLE_SVH
`define TB_J4_IO_TABLE_SVH

// columns: slot, wr, addr, wdata, expected rdata, compare rdata,
// expected port value, port name, extra cycles req stays high after ack
typedef struct {
  slot_t    slot;
  logic     wr;
  io_addr_t addr;       // one-hot io address
  io_word_t wdata;
  io_word_t exp_rdata;
  logic     chk_rd;     // 1 = compare rdata
  io_word_t exp_port;
  string    port;       // output checked once the access is done
  int       hold;
} row_t;

localparam int NUM_ROWS = 38;

row_t rows [NUM_ROWS] = '{
  '{0, 0, 16'h0002, 16'h0000, 16'h0000, 1, 16'h0000, "gpio_oe",    0},  // dir after reset
  '{0, 1, 16'h0001, 16'hFFFF, 16'h0000, 0, 16'hFFFF, "gpio_out",   0},
  '{2, 1, 16'h8000, 16'h00F0, 16'h0000, 0, 16'hFFFF, "gpio_out",   0},  // mask preset
  '{2, 1, 16'h0001, 16'h0000, 16'h0000, 0, 16'hFF0F, "gpio_out",   0},  // only masked bits
  '{2, 1, 16'h0001, 16'h0000, 16'h0000, 0, 16'h0000, "gpio_out",   0},  // mask back to ones
  '{0, 1, 16'h0001, 16'hA5C3, 16'h0000, 0, 16'hA5C3, "gpio_out",   0},
  '{1, 1, 16'h8000, 16'h0FF0, 16'h0000, 0, 16'h0000, "kill_slots", 0},
  '{1, 0, 16'h0001, 16'h0000, 16'h05C0, 1, 16'hA5C3, "gpio_out",   0},  // masked read
  '{1, 0, 16'h0001, 16'h0000, 16'hA5C3, 1, 16'hA5C3, "gpio_out",   0},
  '{0, 1, 16'h0002, 16'h00FF, 16'h0000, 0, 16'h00FF, "gpio_oe",    0},
  '{0, 0, 16'h0002, 16'h0000, 16'h00FF, 1, 16'h00FF, "gpio_oe",    0},
  '{0, 0, 16'h10F8, 16'h0000, 16'h0000, 1, 16'h0000, "none",       0},  // unused bits
  '{0, 1, 16'h0100, 16'h1235, 16'h0000, 0, 16'h0000, "none",       0},  // run-once task
  '{1, 0, 16'h0100, 16'h0000, 16'h1235, 1, 16'h0000, "none",       0},
  '{1, 0, 16'h4000, 16'h0000, 16'h1234, 1, 16'h0000, "none",       0},
  '{1, 0, 16'h4000, 16'h0000, 16'h0000, 1, 16'h0000, "none",       0},  // cleared by fetch
  '{2, 1, 16'h0200, 16'h0400, 16'h0000, 0, 16'h0000, "none",       0},  // even task
  '{2, 0, 16'h4000, 16'h0000, 16'h0400, 1, 16'h0000, "none",       0},
  '{2, 0, 16'h4000, 16'h0000, 16'h0400, 1, 16'h0000, "none",       0},
  '{2, 0, 16'h0200, 16'h0000, 16'h0400, 1, 16'h0000, "none",       0},
  '{0, 1, 16'h0400, 16'h0777, 16'h0000, 0, 16'h0000, "none",       0},
  '{0, 0, 16'h4000, 16'h0000, 16'h0000, 1, 16'h0000, "none",       0},  // slot 0 fetch
  '{0, 0, 16'h0400, 16'h0000, 16'h0777, 1, 16'h0000, "none",       0},
  '{0, 1, 16'h4000, 16'h0006, 16'h0000, 0, 16'h0006, "kill_slots", 0},
  '{0, 1, 16'h0004, 16'h01A5, 16'h0000, 0, 16'h0000, "kill_slots", 0},
  '{0, 0, 16'h0004, 16'h0000, 16'h00A5, 1, 16'h00A5, "leds",       0},
  '{0, 1, 16'h2000, 16'h1C05, 16'h0000, 0, 16'h0001, "flash",      0},  // both ptrs to 5
  '{0, 1, 16'h0800, 16'hBEEF, 16'h0000, 0, 16'h0000, "none",       0},
  '{0, 1, 16'h0800, 16'h0123, 16'h0000, 0, 16'h0000, "none",       0},
  '{0, 1, 16'h0800, 16'h7A5A, 16'h0000, 0, 16'h0000, "none",       0},
  '{0, 0, 16'h0800, 16'h0000, 16'hBEEF, 1, 16'h0000, "none",       0},
  '{0, 0, 16'h0800, 16'h0000, 16'h0123, 1, 16'h0000, "none",       0},
  '{0, 0, 16'h0800, 16'h0000, 16'h7A5A, 1, 16'h0000, "none",       0},
  '{0, 1, 16'h2000, 16'h4000, 16'h0000, 0, 16'h0004, "flash",      0},  // sck only
  '{3, 0, 16'h2000, 16'h0000, 16'h8009, 1, 16'h0004, "flash",      0},  // status
  '{0, 1, 16'h2000, 16'h3000, 16'h0000, 0, 16'h0003, "flash",      0},
  '{0, 0, 16'h2000, 16'h0000, 16'h0007, 1, 16'h0003, "flash",      0},
  '{1, 0, 16'h0001, 16'h0000, 16'hA5C3, 1, 16'hA5C3, "gpio_out",   5}   // long req
};

`endif

// ==== testbench/tb_j4_io.sv ====
`timescale 1ns/1ps

module tb_j4_io;
  import j4_io_pkg::*;

  localparam int ACK_TIMEOUT = 20;  // cycles allowed for each ack edge

  logic        clk;
  logic        resetq;
  logic        req;
  io_req_t     request;
  logic        ack;
  io_word_t    rdata;
  logic [15:0] gpio_in;
  logic [15:0] gpio_out;
  logic [15:0] gpio_oe;
  logic [7:0]  leds;
  logic        flash_sck;
  logic        flash_mosi;
  logic        flash_cs;
  logic        flash_miso;
  logic [3:0]  kill_slots;

  `include "tb_j4_io_table.svh"

  assign gpio_in = gpio_out;  // pins looped back

  j4_io_top #(.GPIO_BITS(16), .LED_BITS(8)) u_j4_io_top (
    .clk        (clk),
    .resetq     (resetq),
    .req        (req),
    .request    (request),
    .ack        (ack),
    .rdata      (rdata),
    .gpio_in    (gpio_in),
    .gpio_out   (gpio_out),
    .gpio_oe    (gpio_oe),
    .leds       (leds),
    .flash_sck  (flash_sck),
    .flash_mosi (flash_mosi),
    .flash_cs   (flash_cs),
    .flash_miso (flash_miso),
    .kill_slots (kill_slots)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  task automatic check_value(input string name, input io_word_t got, input io_word_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string what);
    $display("%s at %0t ns", what, $time);
    $display("Test failed");
    $fatal(1);
  endtask

  // output port named in a table row, widened to a word
  function automatic io_word_t port_value(input string name);
    case (name)
      "gpio_out":   return gpio_out;
      "gpio_oe":    return gpio_oe;
      "leds":       return {8'd0, leds};
      "kill_slots": return {12'd0, kill_slots};
      "flash":      return {13'd0, flash_sck, flash_mosi, flash_cs};
      default:      return 16'h0000;
    endcase
  endfunction

  // one four-phase handshake, inputs change on falling edges only
  task automatic do_access(input slot_t slot, input logic wr, input io_addr_t addr,
                           input io_word_t wdata, input int hold, output io_word_t got);
    int waited;
    @(negedge clk);
    request.wr    = wr;
    request.slot  = slot;
    request.addr  = addr;
    request.wdata = wdata;
    req           = 1'b1;
    waited = 0;
    while (ack !== 1'b1) begin
      @(negedge clk);
      waited++;
      if (waited > ACK_TIMEOUT) abort_run("ack never rose after req");
    end
    got = rdata;
    for (int c = 0; c < hold; c++) begin  // back-pressure, nothing may move
      @(negedge clk);
      check_value("ack", {15'd0, ack}, 16'h0001);
      check_value("rdata", rdata, got);
    end
    req = 1'b0;
    waited = 0;
    while (ack !== 1'b0) begin
      @(negedge clk);
      waited++;
      if (waited > ACK_TIMEOUT) abort_run("ack never fell after req dropped");
    end
  endtask

  initial begin
    io_word_t got;
    io_word_t t_first;
    io_word_t t_second;
    resetq     = 1'b0;
    req        = 1'b0;
    request    = '0;
    flash_miso = 1'b1;
    @(negedge clk);  // first edge of reset has passed
    check_value("ack", {15'd0, ack}, 16'h0000);
    check_value("gpio_oe", gpio_oe, 16'h0000);
    check_value("kill_slots", {12'd0, kill_slots}, 16'h0000);
    check_value("flash_cs", {15'd0, flash_cs}, 16'h0001);
    repeat (2) @(negedge clk);
    resetq = 1'b1;
    @(negedge clk);
    check_value("ack", {15'd0, ack}, 16'h0000);
    check_value("gpio_oe", gpio_oe, 16'h0000);
    check_value("kill_slots", {12'd0, kill_slots}, 16'h0000);
    check_value("flash_cs", {15'd0, flash_cs}, 16'h0001);

    for (int i = 0; i < NUM_ROWS; i++) begin
      do_access(rows[i].slot, rows[i].wr, rows[i].addr, rows[i].wdata, rows[i].hold, got);
      if (rows[i].chk_rd)
        check_value($sformatf("rdata row %0d", i), got, rows[i].exp_rdata);
      if (rows[i].port != "none")
        check_value(rows[i].port, port_value(rows[i].port), rows[i].exp_port);
    end

    // tick counter moves between two reads
    do_access(2'd0, 1'b0, 16'h8000, 16'h0000, 0, t_first);
    do_access(2'd0, 1'b0, 16'h8000, 16'h0000, 0, t_second);
    check_value("ticks differ", {15'd0, (t_second != t_first)}, 16'h0001);
    if (t_first < 16'hFF00)
      check_value("ticks rise", {15'd0, (t_second > t_first)}, 16'h0001);

    $display("Test passed");
    $finish;
  end

endmodule

// ==== j4_io.f ====
+incdir+testbench
hdl/j4_io_pkg.sv
hdl/io_bus_port.sv
hdl/io_mask_bank.sv
hdl/task_slot.sv
hdl/sample_store.sv
hdl/io_control_regs.sv
hdl/io_read_mux.sv
hdl/j4_io_top.sv
testbench/tb_j4_io.sv
